// ==== design/bank_controller.sv ====
`timescale 1ns/1ps

// one bank's row register in front of a single port ram
module bank_controller (
    input logic clock,
    input logic reset,
    bank_if.bank port
);

    bank_pkg::fetch_state_t fetch_state, next_fetch_state;

    logic [grid_pkg::BANK_DEPTH-1:0]      written_list;   // rows ever committed
    logic                                 row_valid;
    logic [grid_pkg::ROW_ADDR_WIDTH-1:0]  row_reg_addr;
    bank_pkg::row_word_t                  row_reg;
    bank_pkg::row_word_t                  ram_read_data;
    bank_pkg::row_word_t                  fetched_row;
    logic [grid_pkg::SLICE_IDX_WIDTH-1:0] slice_idx;

    logic request, hit, fetch_en, writeback_commit, ram_enable;

    assign request   = port.read_en || port.write_en;
    assign slice_idx = port.col_addr[grid_pkg::COL_ADDR_WIDTH-1 -: grid_pkg::SLICE_IDX_WIDTH];

    assign hit      = row_valid && (port.row_addr == row_reg_addr);
    assign fetch_en = request && !hit && (fetch_state == bank_pkg::IDLE);

    assign writeback_commit = (fetch_state == bank_pkg::WRITEBACK);
    assign ram_enable       = fetch_en || writeback_commit;

    single_port_sync_ram u_ram (
        .clock      (clock),
        .enable     (ram_enable),
        .write_en   (writeback_commit),
        .addr       (port.row_addr),
        .write_data (row_reg),
        .read_data  (ram_read_data)
    );

    ////////////////////////////////////////////////////////////////////
    // fetch / writeback sequencing
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        next_fetch_state = fetch_state;
        case (fetch_state)
            bank_pkg::IDLE: begin
                if (fetch_en) begin
                    next_fetch_state = bank_pkg::FETCH_SAVE;
                end else if (hit && port.write_en) begin
                    next_fetch_state = bank_pkg::WRITEBACK;   // write hit
                end
            end
            bank_pkg::FETCH_SAVE: begin
                if (port.write_en) begin
                    next_fetch_state = bank_pkg::WRITEBACK;
                end else begin
                    next_fetch_state = bank_pkg::IDLE;        // read hits next cycle
                end
            end
            bank_pkg::WRITEBACK: next_fetch_state = bank_pkg::IDLE;
            default:             next_fetch_state = bank_pkg::IDLE;
        endcase
    end

    // unwritten rows come back as zero with the write slice merged on top
    always_comb begin
        fetched_row.flat = written_list[port.row_addr] ? ram_read_data.flat : '0;
        if (port.write_en) begin
            fetched_row.slices[slice_idx] = port.wdata;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            fetch_state  <= bank_pkg::IDLE;
            row_valid    <= 1'b0;
            written_list <= '0;
        end else begin
            fetch_state <= next_fetch_state;
            if (fetch_state == bank_pkg::FETCH_SAVE) begin
                row_valid <= 1'b1;
            end
            if (writeback_commit) begin
                written_list[port.row_addr] <= 1'b1;
            end
        end
    end

    // row payload
    always_ff @(posedge clock) begin
        if (fetch_state == bank_pkg::FETCH_SAVE) begin
            row_reg      <= fetched_row;
            row_reg_addr <= port.row_addr;
        end else if (fetch_state == bank_pkg::IDLE && hit && port.write_en) begin
            row_reg.slices[slice_idx] <= port.wdata;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // response
    ////////////////////////////////////////////////////////////////////

    assign port.ack   = (port.read_en && hit) || writeback_commit;
    assign port.busy  = request;
    assign port.rdata = row_reg.slices[slice_idx];

    // one direction at a time
    a_one_direction: assert property (
        @(posedge clock) disable iff (reset)
        !(port.read_en && port.write_en)
    );

    // writeback commits to the address that was fetched
    a_fetch_addr_stable: assert property (
        @(posedge clock) disable iff (reset)
        (fetch_state == bank_pkg::FETCH_SAVE && next_fetch_state == bank_pkg::WRITEBACK)
        |=> $stable(port.row_addr)
    );

    a_no_ack_in_fetch: assert property (
        @(posedge clock) disable iff (reset)
        (fetch_state == bank_pkg::FETCH_SAVE) |-> !port.ack
    );

endmodule

// ==== design/bank_if.sv ====
`timescale 1ns/1ps

// one bank's request and response lines
interface bank_if;

    // request side held until ack
    logic                                read_en;
    logic                                write_en;
    logic [grid_pkg::ROW_ADDR_WIDTH-1:0] row_addr;
    logic [grid_pkg::COL_ADDR_WIDTH-1:0] col_addr;
    bank_pkg::slice_t                    wdata;

    // response side
    logic                                ack;
    logic                                busy;
    bank_pkg::slice_t                    rdata;   // valid in the ack cycle of a read

    modport router (
        output read_en,
        output write_en,
        output row_addr,
        output col_addr,
        output wdata,
        input  ack,
        input  busy,
        input  rdata
    );

    modport bank (
        input  read_en,
        input  write_en,
        input  row_addr,
        input  col_addr,
        input  wdata,
        output ack,
        output busy,
        output rdata
    );

endinterface

// ==== design/bank_pkg.sv ====
package bank_pkg;

    ////////////////////////////////////////////////////////////////////
    // data words
    ////////////////////////////////////////////////////////////////////

    typedef logic [grid_pkg::SLICE_BITS-1:0] slice_t;

    // one row seen whole or slice by slice
    typedef union packed {
        logic [grid_pkg::ROW_BITS-1:0]             flat;
        slice_t [grid_pkg::SLICES_PER_ROW-1:0]     slices;
    } row_word_t;

    ////////////////////////////////////////////////////////////////////
    // controller state
    ////////////////////////////////////////////////////////////////////

    // IDLE        serve hits and start fetches
    // FETCH_SAVE  ram word arrives for capture and merge
    // WRITEBACK   commit row register and ack the write
    typedef enum logic [1:0] {
        IDLE,
        FETCH_SAVE,
        WRITEBACK
    } fetch_state_t;

endpackage

// ==== design/bank_router.sv ====
`timescale 1ns/1ps

// steers the single outstanding request to one bank
module bank_router (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                read_en,
    input  logic                                write_en,
    input  logic [grid_pkg::BANK_SEL_WIDTH-1:0] bank_sel,
    input  logic [grid_pkg::ROW_ADDR_WIDTH-1:0] row_addr,
    input  logic [grid_pkg::COL_ADDR_WIDTH-1:0] col_addr,
    input  bank_pkg::slice_t                    wdata,
    output logic                                ack,
    output logic                                busy,
    output bank_pkg::slice_t                    rdata,
    bank_if.router                              banks [grid_pkg::BANK_COUNT]
);

    logic [grid_pkg::BANK_COUNT-1:0] bank_hot;    // decoded select
    logic [grid_pkg::BANK_COUNT-1:0] bank_ack;
    logic [grid_pkg::BANK_COUNT-1:0] bank_busy;
    bank_pkg::slice_t                bank_rdata [grid_pkg::BANK_COUNT];

    assign bank_hot = grid_pkg::BANK_COUNT'(1) << bank_sel;

    ////////////////////////////////////////////////////////////////////
    // fan out and collect back
    ////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < grid_pkg::BANK_COUNT; i++) begin : g_bank
        // only the selected bank sees an enable
        assign banks[i].read_en  = read_en && bank_hot[i];
        assign banks[i].write_en = write_en && bank_hot[i];

        assign banks[i].row_addr = row_addr;
        assign banks[i].col_addr = col_addr;
        assign banks[i].wdata    = wdata;

        assign bank_ack[i]   = banks[i].ack;
        assign bank_busy[i]  = banks[i].busy;
        assign bank_rdata[i] = banks[i].rdata;
    end

    assign ack   = bank_ack[bank_sel];
    assign rdata = bank_rdata[bank_sel];
    assign busy  = |bank_busy;     // any bank with a request raised

    // request is held unchanged until the bank acks it
    a_request_held: assert property (
        @(posedge clock) disable iff (reset)
        ((read_en || write_en) && !ack)
        |=> $stable({read_en, write_en, bank_sel, row_addr, col_addr, wdata})
    );

endmodule

// ==== design/grid_memory.sv ====
`timescale 1ns/1ps

// banked grid row memory top level
module grid_memory (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic                                  read_en,
    input  logic                                  write_en,
    input  logic [grid_pkg::BANK_SEL_WIDTH-1:0]   bank_sel,
    input  logic [grid_pkg::ROW_ADDR_WIDTH-1:0]   row_addr,
    input  logic [grid_pkg::COL_ADDR_WIDTH-1:0]   col_addr,
    input  logic [$bits(bank_pkg::slice_t)-1:0]   wdata,
    output logic                                  ack,
    output logic                                  busy,
    output logic [$bits(bank_pkg::slice_t)-1:0]   rdata
);

    bank_if bank_links [grid_pkg::BANK_COUNT] ();

    ////////////////////////////////////////////////////////////////////
    // router
    ////////////////////////////////////////////////////////////////////

    bank_router u_router (
        .clock    (clock),
        .reset    (reset),
        .read_en  (read_en),
        .write_en (write_en),
        .bank_sel (bank_sel),
        .row_addr (row_addr),
        .col_addr (col_addr),
        .wdata    (wdata),
        .ack      (ack),
        .busy     (busy),
        .rdata    (rdata),
        .banks    (bank_links)
    );

    ////////////////////////////////////////////////////////////////////
    // banks
    ////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < grid_pkg::BANK_COUNT; i++) begin : g_bank
        bank_controller u_bank (
            .clock (clock),
            .reset (reset),
            .port  (bank_links[i])
        );
    end

endmodule

// ==== design/grid_pkg.sv ====
package grid_pkg;

    ////////////////////////////////////////////////////////////////////
    // row geometry
    ////////////////////////////////////////////////////////////////////

    localparam int ROW_BITS       = 64;   // one grid row with one bit per cell
    localparam int SLICE_BITS     = 8;    // client transfer width
    localparam int SLICES_PER_ROW = ROW_BITS / SLICE_BITS;

    // column bits below a slice are ignored
    localparam int COL_ADDR_WIDTH  = 6;
    localparam int SLICE_IDX_WIDTH = COL_ADDR_WIDTH - $clog2(SLICE_BITS);

    ////////////////////////////////////////////////////////////////////
    // bank geometry
    ////////////////////////////////////////////////////////////////////

    localparam int ROW_ADDR_WIDTH = 5;
    localparam int BANK_DEPTH     = 1 << ROW_ADDR_WIDTH;   // rows per bank

    localparam int BANK_COUNT     = 4;
    localparam int BANK_SEL_WIDTH = $clog2(BANK_COUNT);

endpackage

// ==== design/single_port_sync_ram.sv ====
`timescale 1ns/1ps

// block ram for one bank with one row per address
module single_port_sync_ram (
    input  logic                                clock,
    input  logic                                enable,
    input  logic                                write_en,
    input  logic [grid_pkg::ROW_ADDR_WIDTH-1:0] addr,
    input  bank_pkg::row_word_t                 write_data,
    output bank_pkg::row_word_t                 read_data
);

    logic [grid_pkg::ROW_BITS-1:0] storage [grid_pkg::BANK_DEPTH];

    ////////////////////////////////////////////////////////////////////
    // read first with one cycle latency
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (enable) begin
            if (write_en) begin
                storage[addr] <= write_data.flat;
            end
            read_data.flat <= storage[addr];   // old word during a write
        end
    end

endmodule

// ==== grid_memory.f ====
design/grid_pkg.sv
design/bank_pkg.sv
design/bank_if.sv
design/single_port_sync_ram.sv
design/bank_controller.sv
design/bank_router.sv
design/grid_memory.sv
test/clock_gen.sv
test/grid_memory_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the grid memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BINARY=grid_memory_sim
LOG_FILE=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module grid_memory_tb \
    -f grid_memory.f \
    --Mdir "$BUILD_DIR" -o "$SIM_BINARY"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BINARY" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"

if grep -q "SIMULATION FAILED" "$LOG_FILE"; then
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi
exit 0

// ==== test/clock_gen.sv ====
`timescale 1ns/1ps

// testbench clock and power-on reset
module clock_gen (
    output logic clock,
    output logic reset
);

    localparam real PERIOD_NS    = 8.0;
    localparam int  RESET_CYCLES = 5;

    initial begin
        clock = 1'b0;
        forever #(PERIOD_NS / 2.0) clock = ~clock;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;   // released on a rising edge like the other inputs
    end

endmodule

// ==== test/grid_memory_tb.sv ====
`timescale 1ns/1ps

module grid_memory_tb;

    localparam int NUM_OPS        = 2000;
    localparam int TIMEOUT_CYCLES = NUM_OPS * 4 + 100;
    localparam int RANDOM_SEED    = 7;

    typedef logic [grid_pkg::BANK_SEL_WIDTH-1:0]  bank_sel_t;
    typedef logic [grid_pkg::ROW_ADDR_WIDTH-1:0]  row_addr_t;
    typedef logic [grid_pkg::COL_ADDR_WIDTH-1:0]  col_addr_t;
    typedef logic [grid_pkg::SLICE_IDX_WIDTH-1:0] slice_idx_t;
    typedef logic [grid_pkg::SLICE_BITS-1:0]      slice_word_t;

    logic        clock;
    logic        reset;
    logic        read_en;
    logic        write_en;
    bank_sel_t   bank_sel;
    row_addr_t   row_addr;
    col_addr_t   col_addr;
    slice_word_t wdata;
    logic        ack;
    logic        busy;
    slice_word_t rdata;

    // expected contents of every slice of every row of every bank
    slice_word_t model [grid_pkg::BANK_COUNT][grid_pkg::BANK_DEPTH][grid_pkg::SLICES_PER_ROW];
    logic        cached_valid [grid_pkg::BANK_COUNT];   // row held in each bank's register
    row_addr_t   cached_row   [grid_pkg::BANK_COUNT];

    row_addr_t   row_pool [4];
    int          cycle_count = 0;
    int          error_count = 0;

    clock_gen u_clock_gen (
        .clock (clock),
        .reset (reset)
    );

    grid_memory u_dut (
        .clock    (clock),
        .reset    (reset),
        .read_en  (read_en),
        .write_en (write_en),
        .bank_sel (bank_sel),
        .row_addr (row_addr),
        .col_addr (col_addr),
        .wdata    (wdata),
        .ack      (ack),
        .busy     (busy),
        .rdata    (rdata)
    );

    //////////////////////////////////////////////////////////////////////
    // checking
    //////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            error_count++;
            $display("Error at %0t ns: %s = 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            $display("SIMULATION FAILED");
            $fatal(1, "first mismatch, run stopped");
        end
    endtask

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: ack never arrived within %0d cycles", TIMEOUT_CYCLES);
            $display("SIMULATION FAILED");
            $fatal(1, "run stopped by timeout");
        end
    end

    //////////////////////////////////////////////////////////////////////
    // bus driving
    //////////////////////////////////////////////////////////////////////

    // one request held until ack with latency and data checked against the model
    task automatic run_access(input logic is_write, input bank_sel_t bank,
                              input row_addr_t row, input col_addr_t col,
                              input slice_word_t data);
        int         latency;
        int         expected_latency;
        logic       expect_hit;
        slice_idx_t slice;
        latency    = 0;
        slice      = slice_idx_t'(int'(col) / grid_pkg::SLICE_BITS);
        expect_hit = cached_valid[bank] && (cached_row[bank] == row);
        if (is_write) begin
            expected_latency = expect_hit ? 1 : 2;
        end else begin
            expected_latency = expect_hit ? 0 : 2;
        end

        @(posedge clock);
        read_en  <= !is_write;
        write_en <= is_write;
        bank_sel <= bank;
        row_addr <= row;
        col_addr <= col;
        wdata    <= data;

        @(negedge clock);
        while (ack !== 1'b1) begin
            check_value("busy", 64'(busy), 64'(1));
            latency++;
            @(negedge clock);
        end
        check_value("busy", 64'(busy), 64'(1));
        check_value("ack latency", 64'(latency), 64'(expected_latency));

        if (is_write) begin
            model[bank][row][slice] = data;
        end else begin
            check_value("rdata", 64'(rdata), 64'(model[bank][row][slice]));
        end
        cached_valid[bank] = 1'b1;
        cached_row[bank]   = row;
    endtask

    task automatic idle_cycle();
        @(posedge clock);
        read_en  <= 1'b0;
        write_en <= 1'b0;
        @(negedge clock);
        check_value("ack", 64'(ack), 64'(0));
        check_value("busy", 64'(busy), 64'(0));
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic        is_write;
        bank_sel_t   bank;
        row_addr_t   row;
        col_addr_t   col;
        slice_word_t data;
        logic [1:0]  pool_idx;

        read_en  = 1'b0;
        write_en = 1'b0;
        bank_sel = '0;
        row_addr = '0;
        col_addr = '0;
        wdata    = '0;

        void'($urandom(RANDOM_SEED));
        row_pool[0] = row_addr_t'(0);   // few rows so hits are frequent
        row_pool[1] = row_addr_t'(5);
        row_pool[2] = row_addr_t'(17);
        row_pool[3] = row_addr_t'(31);
        for (int b = 0; b < grid_pkg::BANK_COUNT; b++) begin
            cached_valid[b] = 1'b0;
            cached_row[b]   = '0;
            for (int r = 0; r < grid_pkg::BANK_DEPTH; r++) begin
                for (int s = 0; s < grid_pkg::SLICES_PER_ROW; s++) begin
                    model[b][r][s] = '0;
                end
            end
        end

        // quiet through reset and one cycle after
        @(negedge clock);
        while (reset) begin
            check_value("ack", 64'(ack), 64'(0));
            check_value("busy", 64'(busy), 64'(0));
            @(negedge clock);
        end
        check_value("ack", 64'(ack), 64'(0));
        check_value("busy", 64'(busy), 64'(0));

        // directed pass over the bank behaviours
        run_access(1'b0, 2'd0, 5'd3, 6'd8, 8'h00);    // never written so reads zero
        run_access(1'b1, 2'd0, 5'd3, 6'd8, 8'ha5);    // write hit
        run_access(1'b0, 2'd0, 5'd3, 6'd9, 8'h00);    // read hit right after
        run_access(1'b0, 2'd0, 5'd3, 6'd16, 8'h00);   // neighbour slice untouched
        run_access(1'b1, 2'd1, 5'd3, 6'd8, 8'h3c);    // same row and column in the other bank
        run_access(1'b0, 2'd0, 5'd3, 6'd8, 8'h00);
        run_access(1'b0, 2'd0, 5'd7, 6'd0, 8'h00);    // other row acks in its third cycle
        run_access(1'b0, 2'd0, 5'd3, 6'd8, 8'h00);    // back from ram
        run_access(1'b0, 2'd1, 5'd3, 6'd8, 8'h00);
        idle_cycle();

        for (int op = 0; op < NUM_OPS; op++) begin
            is_write = ($urandom_range(0, 1) == 1);
            bank     = bank_sel_t'($urandom_range(0, grid_pkg::BANK_COUNT - 1));
            pool_idx = 2'($urandom_range(0, 3));
            row      = row_pool[pool_idx];
            col      = col_addr_t'($urandom());
            data     = slice_word_t'($urandom());
            run_access(is_write, bank, row, col, data);
            if ($urandom_range(0, 7) == 0) begin
                idle_cycle();
            end
        end
        idle_cycle();

        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
